//--- hdl/draw_config.svh
`ifndef DRAW_CONFIG_SVH
`define DRAW_CONFIG_SVH

`define LANES 4

// screen geometry
`define LANE_H 60 // rows per lane band
`define BAND_TOP 200 // first row of lane 0
`define BUTTON_X 420 // key indicator starts here
`define SPRITE_W 60 // row stride inside a sprite

// sprite ROM bases
`define BASE_CLICK 12480
`define BASE_SB 14640
`define BASE_SB_D 15720
`define BASE_SE 16800
`define BASE_SE_D 17880
`define BASE_SS 18960
`define BASE_SS_D 19020
`define BASE_DOWN 19080
`define BASE_UP 22680

// ROM read latency in cycles
`define FETCH_LAT 3

`define POS_W 32
`define COORD_W 10
`define XIDX_W 8
`define ROM_AW 15
`define ROM_DW 16

`endif

//--- hdl/draw_pkg.sv
`include "draw_config.svh"

package draw_pkg;

	typedef logic [1:0] lane_t;

	// one note slot as seen by the drawing side
	typedef struct packed {
		logic click;
		logic slide_begin;
		logic slide_end;
		logic slide_space;
		logic discarded; // picks the alternate sprite
		logic [`XIDX_W-1:0] x_idx; // sprite column
	} note_t;

	typedef note_t [`LANES-1:0] lane_notes_t;

	// r sits in the low nibble, as in the ROM word
	typedef struct packed {
		logic [3:0] b;
		logic [3:0] g;
		logic [3:0] r;
	} rgb_t;

	typedef logic [`POS_W-1:0] pos_t;
	typedef logic [`COORD_W-1:0] coord_t;

	typedef logic [`ROM_AW-1:0] rom_addr_t;
	typedef logic [`ROM_DW-1:0] rom_data_t;

endpackage

//--- hdl/frame_ctrl.sv
module frame_ctrl
	import draw_pkg::*;
(
	input logic CLK,
	input logic RESET_L,
	input logic sig_on,
	input pos_t current_pixel,
	output logic vga_reset,
	output logic first_frame,
	output logic ping_pong,
	output pos_t refresh_pixel
);

	logic working;
	pos_t snap [0:1]; // playback position per buffer

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			working <= 1'b0;
			first_frame <= 1'b1;
			ping_pong <= 1'b0;
		end else if (sig_on) begin
			if (!working)
				working <= 1'b1;
			else
				first_frame <= 1'b0; // second strobe onwards
			ping_pong <= ~ping_pong;
		end
	end

	// store into the half that becomes the refresh buffer
	always_ff @(posedge CLK) begin
		if (sig_on)
			snap[~ping_pong] <= current_pixel;
	end

	assign refresh_pixel = snap[ping_pong];
	assign vga_reset = ~working;

endmodule

//--- hdl/refresh_fsm.sv
module refresh_fsm
	import draw_pkg::*;
(
	input logic CLK,
	input logic RESET_L,
	input logic sig_on,
	input logic refresh_done,
	output logic refresh_on,
	output lane_t refresh_lane,
	output logic sig_done
);

	typedef enum logic [3:0] {
		s_idle,
		s_ref_0, s_wait_0,
		s_ref_1, s_wait_1,
		s_ref_2, s_wait_2,
		s_ref_3, s_wait_3,
		s_done
	} state_t;

	state_t state, n_state;

	always_ff @(posedge CLK) begin
		if (!RESET_L)
			state <= s_idle;
		else
			state <= n_state;
	end

	always_comb begin
		n_state = state;
		case (state)
			s_idle: if (sig_on) n_state = s_ref_0; // strobes mid-refresh are dropped
			s_ref_0: n_state = s_wait_0;
			s_wait_0: if (refresh_done) n_state = s_ref_1;
			s_ref_1: n_state = s_wait_1;
			s_wait_1: if (refresh_done) n_state = s_ref_2;
			s_ref_2: n_state = s_wait_2;
			s_wait_2: if (refresh_done) n_state = s_ref_3;
			s_ref_3: n_state = s_wait_3;
			s_wait_3: if (refresh_done) n_state = s_done;
			default: n_state = s_idle;
		endcase
	end

	always_comb begin
		refresh_on = 1'b0;
		refresh_lane = 2'd0;
		case (state)
			s_ref_0: refresh_on = 1'b1;
			s_ref_1: begin
				refresh_on = 1'b1;
				refresh_lane = 2'd1;
			end
			s_ref_2: begin
				refresh_on = 1'b1;
				refresh_lane = 2'd2;
			end
			s_ref_3: begin
				refresh_on = 1'b1;
				refresh_lane = 2'd3;
			end
			s_wait_1: refresh_lane = 2'd1;
			s_wait_2: refresh_lane = 2'd2;
			s_wait_3: refresh_lane = 2'd3;
			default: refresh_lane = 2'd0;
		endcase
	end

	assign sig_done = (state == s_done);

endmodule

//--- hdl/sprite_addr_gen.sv
`include "draw_config.svh"

module sprite_addr_gen
	import draw_pkg::*;
(
	input coord_t vga_x,
	input coord_t vga_y,
	input logic vga_request,
	input logic first_frame,
	input lane_notes_t lane_notes,
	input logic [3:0] is_key_down,
	output rom_addr_t addr,
	output logic fetch_start,
	output logic next_line,
	output lane_t next_line_lane
);

	logic in_band;
	lane_t band;
	rom_addr_t row_off;
	note_t cur;
	rom_addr_t base;
	rom_addr_t idx;
	logic hit;

	// which lane band the row falls in
	always_comb begin
		in_band = 1'b0;
		band = '0;
		row_off = '0;
		for (int i = 0; i < `LANES; i++) begin
			if (vga_y >= coord_t'(`BAND_TOP + i * `LANE_H) &&
					vga_y < coord_t'(`BAND_TOP + (i + 1) * `LANE_H)) begin
				in_band = 1'b1;
				band = lane_t'(i);
				row_off = rom_addr_t'(vga_y - coord_t'(`BAND_TOP + i * `LANE_H));
			end
		end
	end

	assign cur = lane_notes[band];

	always_comb begin
		base = '0;
		idx = '0;
		hit = 1'b1;
		if (vga_x < coord_t'(`BUTTON_X)) begin
			idx = rom_addr_t'(cur.x_idx);
			// click wins over the slide kinds
			if (cur.click)
				base = rom_addr_t'(`BASE_CLICK);
			else if (cur.slide_begin)
				base = cur.discarded ? rom_addr_t'(`BASE_SB_D) : rom_addr_t'(`BASE_SB);
			else if (cur.slide_end)
				base = cur.discarded ? rom_addr_t'(`BASE_SE_D) : rom_addr_t'(`BASE_SE);
			else if (cur.slide_space)
				base = cur.discarded ? rom_addr_t'(`BASE_SS_D) : rom_addr_t'(`BASE_SS);
			else
				hit = 1'b0; // empty slot
		end else begin
			idx = rom_addr_t'(vga_x - coord_t'(`BUTTON_X));
			base = is_key_down[band] ? rom_addr_t'(`BASE_DOWN) : rom_addr_t'(`BASE_UP);
		end
	end

	assign addr = (in_band && hit) ? base + rom_addr_t'(idx * `SPRITE_W) + row_off : '0;
	assign fetch_start = vga_request && !first_frame;

	// line advance on the row after each band
	always_comb begin
		next_line = 1'b0;
		next_line_lane = '0;
		for (int i = 0; i < `LANES; i++) begin
			if (vga_request && vga_y == coord_t'(`BAND_TOP + (i + 1) * `LANE_H)) begin
				next_line = 1'b1;
				next_line_lane = lane_t'(i);
			end
		end
	end

endmodule

//--- hdl/sprite_fetch.sv
`include "draw_config.svh"

module sprite_fetch
	import draw_pkg::*;
(
	input logic CLK,
	input logic RESET_L,
	input logic vga_request,
	input logic fetch_start,
	input rom_addr_t addr,
	input rom_data_t ds_data,
	output rom_addr_t ds_addr,
	output logic ds_en,
	output rgb_t vga_rgb
);

	logic [1:0] lat_cnt;

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			ds_en <= 1'b0;
			lat_cnt <= 2'd0;
			vga_rgb <= '0;
		end else if (fetch_start) begin
			ds_en <= 1'b1; // restart drops any fetch in flight
			lat_cnt <= 2'd1;
		end else if (vga_request) begin
			vga_rgb <= '0; // first frame shows black
		end else if (ds_en) begin
			if (lat_cnt == 2'(`FETCH_LAT)) begin
				vga_rgb <= rgb_t'(ds_data[11:0]);
				ds_en <= 1'b0;
				lat_cnt <= 2'd0;
			end else begin
				lat_cnt <= lat_cnt + 2'd1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (fetch_start)
			ds_addr <= addr;
	end

endmodule

//--- hdl/draw_top.sv
module draw_top
	import draw_pkg::*;
(
	input logic CLK,
	input logic RESET_L,
	input logic sig_on,
	output logic sig_done,
	input pos_t current_pixel,
	input logic refresh_done,
	input lane_notes_t lane_notes,
	input logic [3:0] is_key_down,
	input coord_t vga_x,
	input coord_t vga_y,
	input logic vga_request,
	input rom_data_t ds_data,
	output logic refresh_on,
	output lane_t refresh_lane,
	output logic refresh_buf,
	output pos_t refresh_pixel,
	output logic draw_buf,
	output logic next_line,
	output lane_t next_line_lane,
	output logic vga_reset,
	output rom_addr_t ds_addr,
	output logic ds_en,
	output rgb_t vga_rgb
);

	logic ping_pong;
	logic first_frame;
	rom_addr_t addr;
	logic fetch_start;

	frame_ctrl i_frame_ctrl (
		.CLK(CLK),
		.RESET_L(RESET_L),
		.sig_on(sig_on),
		.current_pixel(current_pixel),
		.vga_reset(vga_reset),
		.first_frame(first_frame),
		.ping_pong(ping_pong),
		.refresh_pixel(refresh_pixel)
	);

	refresh_fsm i_refresh_fsm (
		.CLK(CLK),
		.RESET_L(RESET_L),
		.sig_on(sig_on),
		.refresh_done(refresh_done),
		.refresh_on(refresh_on),
		.refresh_lane(refresh_lane),
		.sig_done(sig_done)
	);

	sprite_addr_gen i_sprite_addr_gen (
		.vga_x(vga_x),
		.vga_y(vga_y),
		.vga_request(vga_request),
		.first_frame(first_frame),
		.lane_notes(lane_notes),
		.is_key_down(is_key_down),
		.addr(addr),
		.fetch_start(fetch_start),
		.next_line(next_line),
		.next_line_lane(next_line_lane)
	);

	sprite_fetch i_sprite_fetch (
		.CLK(CLK),
		.RESET_L(RESET_L),
		.vga_request(vga_request),
		.fetch_start(fetch_start),
		.addr(addr),
		.ds_data(ds_data),
		.ds_addr(ds_addr),
		.ds_en(ds_en),
		.vga_rgb(vga_rgb)
	);

	// refresh one half, draw the other
	assign refresh_buf = ping_pong;
	assign draw_buf = ~ping_pong;

endmodule

//--- verification/draw_sva.sv
`include "draw_config.svh"

module draw_sva (
	input logic CLK,
	input logic RESET_L,
	input logic refresh_on,
	input logic sig_done,
	input logic fetch_start,
	input logic ds_en
);
	timeunit 1ns;
	timeprecision 1ps;

	// one strobe per lane
	a_refresh_on_pulse: assert property (@(posedge CLK) disable iff (!RESET_L)
		refresh_on |=> !refresh_on)
		else $error("refresh_on high for two cycles");

	a_sig_done_pulse: assert property (@(posedge CLK) disable iff (!RESET_L)
		sig_done |=> !sig_done)
		else $error("sig_done high for two cycles");

	// enable still up at the last latency edge
	a_fetch_hold: assert property (@(posedge CLK) disable iff (!RESET_L)
		fetch_start |-> ##`FETCH_LAT ds_en)
		else $error("ds_en dropped before the fetch latency");

	a_fetch_fall: assert property (@(posedge CLK) disable iff (!RESET_L)
		$fell(ds_en) |-> $past(fetch_start, `FETCH_LAT + 1))
		else $error("ds_en fell at the wrong distance from the request");

endmodule

bind draw_top draw_sva i_draw_sva (
	.CLK(CLK),
	.RESET_L(RESET_L),
	.refresh_on(refresh_on),
	.sig_done(sig_done),
	.fetch_start(fetch_start),
	.ds_en(ds_en)
);

//--- verification/draw_tb.sv
`include "draw_config.svh"

module draw_tb
	import draw_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	logic CLK;
	logic RESET_L;
	logic sig_on;
	logic sig_done;
	pos_t current_pixel;
	logic refresh_done;
	lane_notes_t lane_notes;
	logic [3:0] is_key_down;
	coord_t vga_x;
	coord_t vga_y;
	logic vga_request;
	rom_data_t ds_data;
	logic refresh_on;
	lane_t refresh_lane;
	logic refresh_buf;
	pos_t refresh_pixel;
	logic draw_buf;
	logic next_line;
	lane_t next_line_lane;
	logic vga_reset;
	rom_addr_t ds_addr;
	logic ds_en;
	rgb_t vga_rgb;

	typedef struct packed {
		lane_notes_t notes;
		logic [3:0] keys;
		coord_t x;
		coord_t y;
		rom_addr_t exp_addr;
	} row_t;

	localparam int TIMEOUT = 50; // cycles per wait

	row_t table_rows [$];
	int seed;
	int errors;
	int test_errors;
	int tests_run;
	int tests_failed;

	draw_top i_draw_top (.*);

	// sprite ROM model whose word follows the address
	assign ds_data = ds_en ? ({1'b0, ds_addr} ^ 16'h0a5c) : '0;

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		assert (got === exp)
		else begin
			$display("ERR %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic timeout_abort(string what);
		$display("timeout while waiting for %s", what);
		$display("Simulation finished: FAIL");
		$finish;
	endtask

	function automatic logic output_level(string name);
		case (name)
			"refresh_on": return refresh_on;
			"sig_done": return sig_done;
			default: return ds_en;
		endcase
	endfunction

	// polled at falling edges
	task automatic wait_output(string name, logic want, output int cycles);
		cycles = 0;
		while (output_level(name) !== want) begin
			@(negedge CLK);
			cycles++;
			if (cycles > TIMEOUT)
				timeout_abort(name);
		end
	endtask

	task automatic start_test();
		test_errors = errors;
	endtask

	task automatic end_test(string name);
		tests_run++;
		if (errors == test_errors) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed", tests_run, name);
		end
	endtask

	function automatic note_t make_note(logic [3:0] kinds, logic disc, logic [7:0] idx);
		note_t n;
		n.click = kinds[3];
		n.slide_begin = kinds[2];
		n.slide_end = kinds[1];
		n.slide_space = kinds[0];
		n.discarded = disc;
		n.x_idx = idx;
		return n;
	endfunction

	// other lanes hold a click that shows up if the wrong lane is picked
	function automatic lane_notes_t notes_with(int lane, note_t n);
		lane_notes_t ln;
		for (int i = 0; i < `LANES; i++)
			ln[i] = make_note(4'b1000, 1'b0, 8'd70);
		ln[lane] = n;
		return ln;
	endfunction

	function automatic logic [7:0] rand_idx();
		return 8'($random(seed) & 32'h3f);
	endfunction

	function automatic rom_addr_t expect_addr(lane_notes_t notes, logic [3:0] keys,
			coord_t x, coord_t y);
		int row;
		int lane;
		int off;
		int base;
		note_t n;
		row = int'(y) - `BAND_TOP;
		if (row < 0 || row >= `LANES * `LANE_H)
			return '0;
		lane = row / `LANE_H;
		off = row % `LANE_H;
		if (int'(x) >= `BUTTON_X) begin
			base = keys[lane] ? `BASE_DOWN : `BASE_UP;
			return rom_addr_t'(base + (int'(x) - `BUTTON_X) * `SPRITE_W + off);
		end
		n = notes[lane];
		if (n.click)
			base = `BASE_CLICK;
		else if (n.slide_begin)
			base = n.discarded ? `BASE_SB_D : `BASE_SB;
		else if (n.slide_end)
			base = n.discarded ? `BASE_SE_D : `BASE_SE;
		else if (n.slide_space)
			base = n.discarded ? `BASE_SS_D : `BASE_SS;
		else
			return '0;
		return rom_addr_t'(base + int'(n.x_idx) * `SPRITE_W + off);
	endfunction

	task automatic add_row(lane_notes_t notes, logic [3:0] keys, int x, int y);
		row_t r;
		r.notes = notes;
		r.keys = keys;
		r.x = coord_t'(x);
		r.y = coord_t'(y);
		r.exp_addr = expect_addr(r.notes, r.keys, r.x, r.y);
		table_rows.push_back(r);
	endtask

	task automatic build_table();
		add_row(notes_with(0, make_note(4'b1000, 1'b0, rand_idx())), 4'b0000, 100, 205);
		add_row(notes_with(1, make_note(4'b1100, 1'b1, rand_idx())), 4'b0000, 50, 275);
		add_row(notes_with(2, make_note(4'b0100, 1'b0, rand_idx())), 4'b0000, 300, 390);
		add_row(notes_with(3, make_note(4'b0100, 1'b1, rand_idx())), 4'b0000, 419, 430);
		add_row(notes_with(0, make_note(4'b0010, 1'b0, rand_idx())), 4'b0000, 0, 200);
		add_row(notes_with(1, make_note(4'b0010, 1'b1, rand_idx())), 4'b0000, 200, 319);
		add_row(notes_with(2, make_note(4'b0001, 1'b0, rand_idx())), 4'b0000, 150, 350);
		add_row(notes_with(3, make_note(4'b0001, 1'b1, rand_idx())), 4'b0000, 5, 439);
		add_row(notes_with(0, make_note(4'b0011, 1'b0, rand_idx())), 4'b0000, 60, 230);
		add_row(notes_with(1, make_note(4'b0000, 1'b1, rand_idx())), 4'b0000, 10, 300);
		add_row(notes_with(2, make_note(4'b0100, 1'b0, rand_idx())), 4'b0100, 450, 360);
		add_row(notes_with(2, make_note(4'b0100, 1'b0, rand_idx())), 4'b1011, 479, 379);
		add_row(notes_with(1, make_note(4'b0100, 1'b0, rand_idx())), 4'b0010, 420, 260);
		add_row(notes_with(2, make_note(4'b0100, 1'b0, rand_idx())), 4'b0000, 430, 320);
		add_row(notes_with(3, make_note(4'b0100, 1'b0, rand_idx())), 4'b0000, 80, 380);
		add_row(notes_with(0, make_note(4'b1000, 1'b0, rand_idx())), 4'b0000, 100, 440);
		add_row(notes_with(0, make_note(4'b1000, 1'b0, rand_idx())), 4'b0000, 200, 100);
		add_row(notes_with(0, make_note(4'b1000, 1'b0, rand_idx())), 4'b1111, 450, 600);
	endtask

	// caller sits on a falling edge
	task automatic strobe_frame(pos_t pixel);
		sig_on = 1'b1;
		current_pixel = pixel;
		@(negedge CLK);
		sig_on = 1'b0;
	endtask

	task automatic run_refresh();
		int cycles;
		int gap;
		for (int lane = 0; lane < `LANES; lane++) begin
			wait_output("refresh_on", 1'b1, cycles);
			check_value("refresh_on delay", cycles, 0);
			check_value("refresh_lane", 32'(refresh_lane), lane);
			check_value("refresh_buf^draw_buf", 32'(refresh_buf ^ draw_buf), 1);
			check_value("sig_done", 32'(sig_done), 0);
			@(negedge CLK);
			check_value("refresh_on", 32'(refresh_on), 0);
			gap = 1 + ($random(seed) & 3);
			for (int i = 0; i < gap; i++) begin
				@(negedge CLK); // refresher busy
				check_value("refresh_on", 32'(refresh_on), 0);
				check_value("sig_done", 32'(sig_done), 0);
			end
			refresh_done = 1'b1;
			@(negedge CLK);
			refresh_done = 1'b0;
		end
		wait_output("sig_done", 1'b1, cycles);
		check_value("sig_done delay", cycles, 0);
		@(negedge CLK);
		check_value("sig_done", 32'(sig_done), 0);
	endtask

	task automatic apply_row(row_t r);
		int cycles;
		int row_off;
		int nl_lane;
		logic line_end;
		lane_notes = r.notes;
		is_key_down = r.keys;
		vga_x = r.x;
		vga_y = r.y;
		vga_request = 1'b1;
		row_off = int'(r.y) - `BAND_TOP;
		nl_lane = row_off / `LANE_H - 1;
		line_end = row_off > 0 && row_off % `LANE_H == 0 && nl_lane < `LANES;
		@(posedge CLK); // next_line settled since the falling edge
		check_value("next_line", 32'(next_line), 32'(line_end));
		if (line_end)
			check_value("next_line_lane", 32'(next_line_lane), nl_lane);
		@(negedge CLK);
		vga_request = 1'b0;
		check_value("ds_en", 32'(ds_en), 1);
		check_value("ds_addr", 32'(ds_addr), 32'(r.exp_addr));
		wait_output("ds_en", 1'b0, cycles);
		check_value("fetch latency", cycles, `FETCH_LAT);
		check_value("vga_rgb", {20'd0, vga_rgb}, {20'd0, 12'(r.exp_addr) ^ 12'ha5c});
	endtask

	initial begin
		pos_t first_pixel;
		pos_t second_pixel;
		seed = 32'hed0d;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		RESET_L = 1'b0;
		sig_on = 1'b0;
		current_pixel = '0;
		refresh_done = 1'b0;
		lane_notes = '0;
		is_key_down = '0;
		vga_x = '0;
		vga_y = '0;
		vga_request = 1'b0;
		build_table();
		first_pixel = pos_t'($random(seed));
		second_pixel = pos_t'($random(seed));
		repeat (10) @(negedge CLK);
		RESET_L = 1'b1;
		@(negedge CLK);

		start_test();
		check_value("sig_done", 32'(sig_done), 0);
		check_value("refresh_on", 32'(refresh_on), 0);
		check_value("ds_en", 32'(ds_en), 0);
		check_value("vga_rgb", {20'd0, vga_rgb}, 0);
		check_value("vga_reset", 32'(vga_reset), 1);
		end_test("reset values");

		start_test();
		strobe_frame(first_pixel);
		check_value("vga_reset", 32'(vga_reset), 0);
		check_value("refresh_buf", 32'(refresh_buf), 1);
		check_value("refresh_pixel", refresh_pixel, first_pixel);
		run_refresh();
		end_test("first frame refresh");

		start_test();
		vga_x = 10'd100;
		vga_y = 10'd210;
		vga_request = 1'b1;
		@(negedge CLK);
		vga_request = 1'b0;
		check_value("ds_en", 32'(ds_en), 0);
		check_value("vga_rgb", {20'd0, vga_rgb}, 0);
		repeat (`FETCH_LAT) @(negedge CLK);
		check_value("ds_en", 32'(ds_en), 0);
		end_test("first frame blank");

		start_test();
		strobe_frame(second_pixel);
		check_value("refresh_buf", 32'(refresh_buf), 0);
		check_value("refresh_pixel", refresh_pixel, second_pixel);
		check_value("draw snapshot", i_draw_top.i_frame_ctrl.snap[1], first_pixel);
		run_refresh();
		end_test("second frame refresh");

		foreach (table_rows[i]) begin
			start_test();
			apply_row(table_rows[i]);
			end_test($sformatf("pixel row %0d", i));
		end

		$display("tests run %0d, failed %0d, failed checks %0d",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+hdl
hdl/draw_pkg.sv
hdl/frame_ctrl.sv
hdl/refresh_fsm.sv
hdl/sprite_addr_gen.sv
hdl/sprite_fetch.sv
hdl/draw_top.sv
verification/draw_sva.sv
verification/draw_tb.sv

//--- run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module draw_tb -o draw_sim \
	&& ./obj_dir/draw_sim > sim.log 2>&1 \
	|| echo "build or simulation returned an error status"
cat sim.log 2>/dev/null
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0
